// ==== cb_hash_pkg.sv ====
// ---------------------------------------------------------------------
// hash seeding definitions for the counting bloom filter
// one seed pair keys one substitution-permutation hash
// ---------------------------------------------------------------------

package cb_hash_pkg;

  // key of a single hash function
  typedef struct packed {
    // seeds the bit permutation order
    logic [31:0] permute_seed;
    // seeds the round key stream
    logic [31:0] xor_seed;
  } cb_seed_t;

  // ---------------------------------------------------------------------
  // default seed set for three hashes
  // ---------------------------------------------------------------------
  // entry 0 keys the first hash of every hash block
  localparam cb_seed_t [2:0] eg_seeds = '{
    '{
      permute_seed: 32'h3c6e_f372,
      xor_seed:     32'ha54f_f53a
    },
    '{
      permute_seed: 32'h9b05_688c,
      xor_seed:     32'h1f83_d9ab
    },
    '{
      permute_seed: 32'h6a09_e667,
      xor_seed:     32'hbb67_ae85
    }
  };

endpackage

// ==== cb_count_pkg.sv ====
// ---------------------------------------------------------------------
// bucket operation definitions for the filter counter logic
// ---------------------------------------------------------------------

package cb_count_pkg;

  // action applied to one counter in a cycle
  typedef enum logic [1:0] {
    op_hold = 2'b00,
    op_up   = 2'b01,
    op_down = 2'b10
  } bucket_op_e;

  // up and down at once cancel out
  function automatic bucket_op_e decode_op(logic up, logic down);
    case ({up, down})
      2'b10:   return op_up;
      2'b01:   return op_down;
      default: return op_hold;
    endcase
  endfunction

endpackage

// ==== sub_per_hash.sv ====
// ---------------------------------------------------------------------
// keyed substitution-permutation hash
// permutes, key-mixes and substitutes the data word for a number of
// rounds, then decodes its low bits into a one-hot bucket pointer
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module sub_per_hash #(
  parameter int unsigned inp_width   = 32,
  parameter int unsigned hash_width  = 4,
  parameter int unsigned no_rounds   = 1,
  parameter logic [31:0] permute_key = 32'h3c6e_f372,
  parameter logic [31:0] xor_key     = 32'ha54f_f53a
) (
  input  logic [inp_width-1:0]     data_i,
  output logic [2**hash_width-1:0] hash_onehot_o
);

  // width of one permutation table entry
  localparam int unsigned idx_w = (inp_width > 1) ? $clog2(inp_width) : 1;

  // present cipher s-box with entry 0 in the low nibble
  localparam logic [15:0][3:0] sbox = 64'h2174_8fe3_da09_b65c;

  // xorshift32 step for the elaboration-time tables
  function automatic logic [31:0] prng_step(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // fisher-yates shuffle of the bit positions
  function automatic logic [inp_width*idx_w-1:0] gen_perm(logic [31:0] key);
    logic [inp_width*idx_w-1:0] tab;
    logic [idx_w-1:0]           tmp;
    logic [31:0]                state;
    int unsigned                j;
    state = (key == '0) ? 32'h1 : key;
    for (int unsigned i = 0; i < inp_width; i++) begin
      tab[i*idx_w +: idx_w] = idx_w'(i);
    end
    for (int unsigned i = inp_width - 1; i > 0; i--) begin
      state = prng_step(state);
      j     = state % (i + 1);
      tmp   = tab[i*idx_w +: idx_w];
      tab[i*idx_w +: idx_w] = tab[j*idx_w +: idx_w];
      tab[j*idx_w +: idx_w] = tmp;
    end
    return tab;
  endfunction

  // one key word of inp_width bits per round
  function automatic logic [no_rounds*inp_width-1:0] gen_keys(logic [31:0] key);
    logic [no_rounds*inp_width-1:0] stream;
    logic [31:0]                    state;
    state = (key == '0) ? 32'h1 : key;
    for (int unsigned i = 0; i < no_rounds * inp_width; i++) begin
      if (i % 32 == 0) begin
        state = prng_step(state);
      end
      stream[i] = state[i % 32];
    end
    return stream;
  endfunction

  localparam logic [inp_width*idx_w-1:0]     perm_tab = gen_perm(permute_key);
  localparam logic [no_rounds*inp_width-1:0] key_tab  = gen_keys(xor_key);

  logic [inp_width-1:0]  round_word;
  logic [inp_width-1:0]  mix_word;
  logic [hash_width-1:0] bucket_idx;

  always_comb begin
    round_word = data_i;
    mix_word   = '0;
    for (int unsigned r = 0; r < no_rounds; r++) begin
      // bit permutation
      for (int unsigned i = 0; i < inp_width; i++) begin
        mix_word[i] = round_word[perm_tab[i*idx_w +: idx_w]];
      end
      // round key
      mix_word = mix_word ^ key_tab[r*inp_width +: inp_width];
      // nibble substitution
      // leftover top bits pass unchanged
      for (int unsigned n = 0; n < inp_width / 4; n++) begin
        mix_word[n*4 +: 4] = sbox[mix_word[n*4 +: 4]];
      end
      round_word = mix_word;
    end
    // low bits of the last round select the bucket
    bucket_idx                = round_word[hash_width-1:0];
    hash_onehot_o             = '0;
    hash_onehot_o[bucket_idx] = 1'b1;
  end

endmodule

// ==== hash_block.sv ====
// ---------------------------------------------------------------------
// hash block of the counting bloom filter
// runs k keyed hashes in parallel and merges their one-hot pointers
// into one bucket indicator vector
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module hash_block #(
  parameter int unsigned k_hashes    = 3,
  parameter int unsigned inp_width   = 32,
  parameter int unsigned hash_width  = 4,
  parameter int unsigned hash_rounds = 1,
  parameter cb_hash_pkg::cb_seed_t [k_hashes-1:0] seeds = cb_hash_pkg::eg_seeds
) (
  input  logic [inp_width-1:0]     data_i,
  output logic [2**hash_width-1:0] indicator_o
);

  // one-hot pointer of every hash
  logic [k_hashes-1:0][2**hash_width-1:0] onehots;

  // ---------------------------------------------------------------------
  // hash instances
  // ---------------------------------------------------------------------
  for (genvar h = 0; h < k_hashes; h++) begin : gen_hashes
    // each hash gets its own seed pair
    sub_per_hash #(
      .inp_width   (inp_width),
      .hash_width  (hash_width),
      .no_rounds   (hash_rounds),
      .permute_key (seeds[h].permute_seed),
      .xor_key     (seeds[h].xor_seed)
    ) u_hash (
      .data_i        (data_i),
      .hash_onehot_o (onehots[h])
    );
  end

  // ---------------------------------------------------------------------
  // merge pointers
  // ---------------------------------------------------------------------
  // hashes hitting the same bucket collapse to a single bit
  always_comb begin
    indicator_o = '0;
    for (int unsigned h = 0; h < k_hashes; h++) begin
      indicator_o = indicator_o | onehots[h];
    end
  end

endmodule

// ==== filter_counters.sv ====
// ---------------------------------------------------------------------
// counter block of the counting bloom filter
// holds the bucket counters and the usage counter, forms the lookup
// match and the full, empty and sticky error flags
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module filter_counters #(
  parameter int unsigned hash_width   = 4,
  parameter int unsigned bucket_width = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // indicator vectors from the hash blocks
  input  logic [2**hash_width-1:0] look_ind_i,
  input  logic [2**hash_width-1:0] incr_ind_i,
  input  logic [2**hash_width-1:0] decr_ind_i,
  // strobes
  input  logic                     incr_valid_i,
  input  logic                     decr_valid_i,
  input  logic                     filter_clear_i,
  // lookup result and status
  output logic                     look_valid_o,
  output logic [hash_width-1:0]    filter_usage_o,
  output logic                     filter_full_o,
  output logic                     filter_empty_o,
  output logic                     filter_error_o
);

  import cb_count_pkg::*;

  localparam int unsigned no_buckets = 2**hash_width;

  // bucket state
  logic [no_buckets-1:0][bucket_width-1:0] bucket_q;
  bucket_op_e [no_buckets-1:0]             bucket_op;
  logic [no_buckets-1:0]                   bucket_wrap;
  logic [no_buckets-1:0]                   bucket_nz;
  logic [no_buckets-1:0]                   bucket_max;
  // usage state
  logic [hash_width-1:0]                   usage_q;
  bucket_op_e                              usage_op;
  logic                                    usage_wrap;
  // sticky error
  logic                                    error_q;

  // ---------------------------------------------------------------------
  // operation decode and wrap detect
  // ---------------------------------------------------------------------
  always_comb begin
    for (int unsigned i = 0; i < no_buckets; i++) begin
      // a bucket hit by both updates holds
      bucket_op[i]   = decode_op(incr_valid_i & incr_ind_i[i],
                                 decr_valid_i & decr_ind_i[i]);
      bucket_wrap[i] = ((bucket_op[i] == op_up) && (&bucket_q[i])) ||
                       ((bucket_op[i] == op_down) && (bucket_q[i] == '0));
    end
  end

  // usage follows the strobes alone
  assign usage_op   = decode_op(incr_valid_i, decr_valid_i);
  assign usage_wrap = ((usage_op == op_up) && (&usage_q)) ||
                      ((usage_op == op_down) && (usage_q == '0));

  // ---------------------------------------------------------------------
  // counter registers
  // ---------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      bucket_q <= '0;
      usage_q  <= '0;
      error_q  <= 1'b0;
    end else if (filter_clear_i) begin
      // clear wins over any update
      bucket_q <= '0;
      usage_q  <= '0;
      error_q  <= 1'b0;
    end else begin
      for (int unsigned i = 0; i < no_buckets; i++) begin
        case (bucket_op[i])
          op_up:   bucket_q[i] <= bucket_q[i] + bucket_width'(1);
          op_down: bucket_q[i] <= bucket_q[i] - bucket_width'(1);
          default: bucket_q[i] <= bucket_q[i];
        endcase
      end
      case (usage_op)
        op_up:   usage_q <= usage_q + hash_width'(1);
        op_down: usage_q <= usage_q - hash_width'(1);
        default: usage_q <= usage_q;
      endcase
      // any wrap, either way, latches the error
      if ((|bucket_wrap) || usage_wrap) begin
        error_q <= 1'b1;
      end
    end
  end

  // ---------------------------------------------------------------------
  // lookup match and flags
  // ---------------------------------------------------------------------
  always_comb begin
    for (int unsigned i = 0; i < no_buckets; i++) begin
      bucket_nz[i]  = |bucket_q[i];
      bucket_max[i] = &bucket_q[i];
    end
  end

  // every pointed bucket must be occupied
  assign look_valid_o   = ((look_ind_i & bucket_nz) == look_ind_i);
  assign filter_usage_o = usage_q;
  assign filter_full_o  = |bucket_max;
  assign filter_empty_o = ~(|bucket_nz);
  assign filter_error_o = error_q;

endmodule

// ==== cb_filter.sv ====
// ---------------------------------------------------------------------
// counting bloom filter top level
// lookup, increment and decrement hash blocks feed one counter block
// lookups are combinational and updates take one clock edge
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module cb_filter #(
  parameter int unsigned k_hashes     = 3,
  parameter int unsigned hash_width   = 4,
  parameter int unsigned hash_rounds  = 1,
  parameter int unsigned inp_width    = 32,
  parameter int unsigned bucket_width = 4,
  // one seed pair per hash
  parameter cb_hash_pkg::cb_seed_t [k_hashes-1:0] seeds = cb_hash_pkg::eg_seeds
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // lookup
  input  logic [inp_width-1:0]  look_data_i,
  output logic                  look_valid_o,
  // increment
  input  logic [inp_width-1:0]  incr_data_i,
  input  logic                  incr_valid_i,
  // decrement
  input  logic [inp_width-1:0]  decr_data_i,
  input  logic                  decr_valid_i,
  // status
  input  logic                  filter_clear_i,
  output logic [hash_width-1:0] filter_usage_o,
  output logic                  filter_full_o,
  output logic                  filter_empty_o,
  output logic                  filter_error_o
);

  // bucket indicator vectors
  logic [2**hash_width-1:0] look_ind;
  logic [2**hash_width-1:0] incr_ind;
  logic [2**hash_width-1:0] decr_ind;

  // ---------------------------------------------------------------------
  // hash blocks keyed alike so one word maps to the same buckets
  // ---------------------------------------------------------------------
  hash_block #(
    .k_hashes    (k_hashes),
    .inp_width   (inp_width),
    .hash_width  (hash_width),
    .hash_rounds (hash_rounds),
    .seeds       (seeds)
  ) u_look_hashes (
    .data_i      (look_data_i),
    .indicator_o (look_ind)
  );

  hash_block #(
    .k_hashes    (k_hashes),
    .inp_width   (inp_width),
    .hash_width  (hash_width),
    .hash_rounds (hash_rounds),
    .seeds       (seeds)
  ) u_incr_hashes (
    .data_i      (incr_data_i),
    .indicator_o (incr_ind)
  );

  hash_block #(
    .k_hashes    (k_hashes),
    .inp_width   (inp_width),
    .hash_width  (hash_width),
    .hash_rounds (hash_rounds),
    .seeds       (seeds)
  ) u_decr_hashes (
    .data_i      (decr_data_i),
    .indicator_o (decr_ind)
  );

  // ---------------------------------------------------------------------
  // buckets, usage and flags
  // ---------------------------------------------------------------------
  filter_counters #(
    .hash_width   (hash_width),
    .bucket_width (bucket_width)
  ) u_counters (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .look_ind_i     (look_ind),
    .incr_ind_i     (incr_ind),
    .decr_ind_i     (decr_ind),
    .incr_valid_i   (incr_valid_i),
    .decr_valid_i   (decr_valid_i),
    .filter_clear_i (filter_clear_i),
    .look_valid_o   (look_valid_o),
    .filter_usage_o (filter_usage_o),
    .filter_full_o  (filter_full_o),
    .filter_empty_o (filter_empty_o),
    .filter_error_o (filter_error_o)
  );

endmodule

// ==== tb_cb_filter.sv ====
// ---------------------------------------------------------------------
// testbench for the counting bloom filter
// directed tests of reset, insert and remove, mixed strobes and wrap
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module tb_cb_filter;

  // cycles any wait loop may spin
  localparam int unsigned wait_limit = 8;

  logic        clk_i;
  logic        rst_n_i;
  logic [31:0] look_data_i;
  logic        look_valid_o;
  logic [31:0] incr_data_i;
  logic        incr_valid_i;
  logic [31:0] decr_data_i;
  logic        decr_valid_i;
  logic        filter_clear_i;
  logic [3:0]  filter_usage_o;
  logic        filter_full_o;
  logic        filter_empty_o;
  logic        filter_error_o;

  // word source and the words kept for removal
  logic [31:0] lfsr_q;
  logic [31:0] words [8];

  cb_filter u_dut (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .look_data_i    (look_data_i),
    .look_valid_o   (look_valid_o),
    .incr_data_i    (incr_data_i),
    .incr_valid_i   (incr_valid_i),
    .decr_data_i    (decr_data_i),
    .decr_valid_i   (decr_valid_i),
    .filter_clear_i (filter_clear_i),
    .filter_usage_o (filter_usage_o),
    .filter_full_o  (filter_full_o),
    .filter_empty_o (filter_empty_o),
    .filter_error_o (filter_error_o)
  );

  // 8 ns clock
  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // ---------------------------------------------------------------------
  // stimulus helpers
  // ---------------------------------------------------------------------
  // galois lfsr, taps 32 30 26 25
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'ha300_0000;
    end
    return n;
  endfunction

  // one lfsr step per bit of the word
  task automatic next_word(output logic [31:0] w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w      = {w[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  task automatic check_value(string test, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s: expected %0h actual %0h", test, expected, actual);
      $display("Done: errors found");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_status(string test, logic [31:0] usage, logic [31:0] full,
                              logic [31:0] empty, logic [31:0] error);
    check_value({test, " usage"}, usage, 32'(filter_usage_o));
    check_value({test, " full"}, full, 32'(filter_full_o));
    check_value({test, " empty"}, empty, 32'(filter_empty_o));
    check_value({test, " error"}, error, 32'(filter_error_o));
  endtask

  // lookup path is combinational, sample shortly after driving
  task automatic check_lookup(string test, logic [31:0] w, logic [31:0] expected);
    @(negedge clk_i);
    look_data_i = w;
    #1;
    check_value({test, " lookup"}, expected, 32'(look_valid_o));
  endtask

  task automatic drive_update(logic inc, logic dec, logic [31:0] w);
    @(negedge clk_i);
    incr_data_i  = w;
    decr_data_i  = w;
    incr_valid_i = inc;
    decr_valid_i = dec;
  endtask

  task automatic drive_idle();
    @(negedge clk_i);
    incr_valid_i = 1'b0;
    decr_valid_i = 1'b0;
    #1;
  endtask

  task automatic wait_until_empty(string what);
    int unsigned cycles;
    cycles = 0;
    while (!filter_empty_o && cycles < wait_limit) begin
      @(negedge clk_i);
      #1;
      cycles++;
    end
    if (!filter_empty_o) begin
      $display("timeout: filter never became empty after %s", what);
      $display("Done: errors found");
      $fatal(1, "wait for empty timed out");
    end
  endtask

  task automatic wait_until_error(string what);
    int unsigned cycles;
    cycles = 0;
    while (!filter_error_o && cycles < wait_limit) begin
      @(negedge clk_i);
      #1;
      cycles++;
    end
    if (!filter_error_o) begin
      $display("timeout: error flag never rose after %s", what);
      $display("Done: errors found");
      $fatal(1, "wait for error timed out");
    end
  endtask

  // clear pulse, then wait for the empty flag
  task automatic apply_clear();
    @(negedge clk_i);
    filter_clear_i = 1'b1;
    @(negedge clk_i);
    filter_clear_i = 1'b0;
    wait_until_empty("clear");
  endtask

  // ---------------------------------------------------------------------
  // directed tests
  // ---------------------------------------------------------------------
  // all buckets zero so no lookup can match
  task automatic test_empty_state(string test);
    logic [31:0] w;
    check_status(test, 32'd0, 32'd0, 32'd1, 32'd0);
    for (int i = 0; i < 10; i++) begin
      next_word(w);
      check_lookup(test, w, 32'd0);
    end
  endtask

  task automatic test_insert_remove();
    apply_clear();
    for (int i = 0; i < 8; i++) begin
      next_word(words[i]);
      drive_update(1'b1, 1'b0, words[i]);
    end
    drive_idle();
    // at most 8 steps per bucket, far from full
    check_status("insert", 32'd8, 32'd0, 32'd0, 32'd0);
    for (int i = 0; i < 8; i++) begin
      check_lookup("insert", words[i], 32'd1);
    end
    for (int i = 0; i < 8; i++) begin
      drive_update(1'b0, 1'b1, words[i]);
    end
    drive_idle();
    check_status("remove", 32'd0, 32'd0, 32'd1, 32'd0);
    for (int i = 0; i < 8; i++) begin
      check_lookup("remove", words[i], 32'd0);
    end
  endtask

  // same word up and down at once leaves every counter alone
  task automatic test_both_strobes();
    logic [31:0] w;
    apply_clear();
    next_word(w);
    drive_update(1'b1, 1'b0, w);
    drive_idle();
    check_status("both", 32'd1, 32'd0, 32'd0, 32'd0);
    drive_update(1'b1, 1'b1, w);
    drive_idle();
    check_status("both", 32'd1, 32'd0, 32'd0, 32'd0);
    check_lookup("both", w, 32'd1);
  endtask

  task automatic test_wrap();
    logic [31:0] w;
    apply_clear();
    next_word(w);
    repeat (15) drive_update(1'b1, 1'b0, w);
    drive_idle();
    check_status("wrap", 32'd15, 32'd1, 32'd0, 32'd0);
    check_lookup("wrap", w, 32'd1);
    // 16th step rolls buckets and usage back to zero
    drive_update(1'b1, 1'b0, w);
    drive_idle();
    wait_until_error("wrap");
    check_status("wrap", 32'd0, 32'd0, 32'd1, 32'd1);
    repeat (4) begin
      @(negedge clk_i);
      #1;
      check_value("wrap sticky error", 32'd1, 32'(filter_error_o));
    end
  endtask

  task automatic test_clear_state();
    apply_clear();
    test_empty_state("clear");
  endtask

  // ---------------------------------------------------------------------
  // sequence
  // ---------------------------------------------------------------------
  initial begin
    rst_n_i        = 1'b0;
    look_data_i    = '0;
    incr_data_i    = '0;
    incr_valid_i   = 1'b0;
    decr_data_i    = '0;
    decr_valid_i   = 1'b0;
    filter_clear_i = 1'b0;
    lfsr_q         = 32'hdd26_de35;
    // two rising edges in reset
    repeat (2) @(negedge clk_i);
    rst_n_i = 1'b1;
    #1;
    wait_until_empty("reset");
    test_empty_state("reset");
    test_insert_remove();
    test_both_strobes();
    test_wrap();
    test_clear_state();
    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== cb_filter.f ====
cb_hash_pkg.sv
cb_count_pkg.sv
sub_per_hash.sv
hash_block.sv
filter_counters.sv
cb_filter.sv
tb_cb_filter.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the counting bloom filter testbench with verilator
cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log
fail_msg="Done: errors found"

verilator --binary --timing -j 0 -f cb_filter.f --top-module tb_cb_filter \
  -o tb_cb_filter > "$build_log" 2>&1
if [ $? -ne 0 ]; then
  echo "compile failed, see $build_log"
  exit 1
fi

./obj_dir/tb_cb_filter > "$sim_log" 2>&1
run_status=$?

# the log decides, the exit status only backs it up
if grep -q "$fail_msg" "$sim_log"; then
  echo "simulation reported errors, see $sim_log"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status, see $sim_log"
  exit 1
fi

echo "simulation passed"
exit 0
